// ==== design/argmaxSelect.sv ====
`timescale 1ns/1ps
`include "mlpCfg_cfg.svh"

// ********************************************************************
// registered argmax over the output-layer scores
// ********************************************************************

module argmaxSelect
	import mlpPkg::*;
(
	input logic clk,
	input logic reset,
	input sample_t score0,
	input sample_t score1,
	input sample_t score2,
	output classIndex_t classIndex,
	output sample_t classScore
);

	classIndex_t bestIndex;
	sample_t bestScore;

	// scores are scanned in class order and only a strictly larger value
	// replaces the current best, so the lower index keeps a tie.
	always_comb
	begin
		bestIndex = classIndex_t'(0);
		bestScore = score0;

		if (score1 > bestScore)
		begin
			bestIndex = classIndex_t'(1);
			bestScore = score1;
		end

		if (score2 > bestScore)
		begin
			bestIndex = classIndex_t'(2);
			bestScore = score2;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			classIndex <= '0;
			classScore <= '0;
		end
		else
		begin
			classIndex <= bestIndex;
			classScore <= bestScore;
		end
	end

	indexInRange: assert property (
		@(posedge clk) disable iff (reset)
		classIndex < `MLP_NUM_CLASSES
	)
	else
		$error("argmaxSelect: class index %0d out of range", classIndex);

	// the registered winner dominates every score it was chosen from.
	scoreIsMaximum: assert property (
		@(posedge clk) disable iff (reset)
		!$past(reset) |-> (classScore >= $past(score0)) &&
			(classScore >= $past(score1)) && (classScore >= $past(score2))
	)
	else
		$error("argmaxSelect: class score below a previous input score");

endmodule

// ==== design/mlpCfg_cfg.svh ====
`ifndef MLP_CFG_SVH
`define MLP_CFG_SVH

// ********************************************************************
// datapath format
// ********************************************************************

// every value in the network is a signed Q8.8 word.
`define MLP_DATA_W 16
`define MLP_FRAC_BITS 8

// ********************************************************************
// network shape
// ********************************************************************

`define MLP_NUM_FEATURES 4
`define MLP_NUM_HIDDEN 3
`define MLP_NUM_CLASSES 3

// input register, sum register, activation register.
`define MLP_NEURON_LAT 3

`endif

// ==== design/mlpPkg.sv ====
`include "mlpCfg_cfg.svh"

// ********************************************************************
// types shared by the network and its testbench
// ********************************************************************

package mlpPkg;

	// signed Q8.8 word used for features, activations and scores.
	typedef logic signed [`MLP_DATA_W-1:0] sample_t;

	// wide enough to number every output class.
	typedef logic [$clog2(`MLP_NUM_CLASSES)-1:0] classIndex_t;

endpackage

// ==== design/mlpTop.sv ====
`timescale 1ns/1ps
`include "mlpCfg_cfg.svh"
`include "mlpWeights.svh"

// ********************************************************************
// two-layer classifier, seven cycles from features to class
// ********************************************************************

module mlpTop
	import mlpPkg::*;
(
	input logic clk,
	input logic reset,
	input sample_t feature0,
	input sample_t feature1,
	input sample_t feature2,
	input sample_t feature3,
	output classIndex_t classIndex,
	output sample_t classScore
);

	sample_t hidden0;
	sample_t hidden1;
	sample_t hidden2;
	sample_t score0;
	sample_t score1;
	sample_t score2;

	// hidden layer, rectified.
	neuron #(
		.NIN(`MLP_NUM_FEATURES),
		.WEIGHTS(`MLP_HID_W0),
		.BIAS(`MLP_HID_B0),
		.RELU(1'b1)
	) hidden0_i (
		.clk(clk),
		.reset(reset),
		.neuronIn({feature3, feature2, feature1, feature0}),
		.neuronOut(hidden0)
	);

	neuron #(
		.NIN(`MLP_NUM_FEATURES),
		.WEIGHTS(`MLP_HID_W1),
		.BIAS(`MLP_HID_B1),
		.RELU(1'b1)
	) hidden1_i (
		.clk(clk),
		.reset(reset),
		.neuronIn({feature3, feature2, feature1, feature0}),
		.neuronOut(hidden1)
	);

	neuron #(
		.NIN(`MLP_NUM_FEATURES),
		.WEIGHTS(`MLP_HID_W2),
		.BIAS(`MLP_HID_B2),
		.RELU(1'b1)
	) hidden2_i (
		.clk(clk),
		.reset(reset),
		.neuronIn({feature3, feature2, feature1, feature0}),
		.neuronOut(hidden2)
	);

	// output layer, linear scores.
	neuron #(
		.NIN(`MLP_NUM_HIDDEN),
		.WEIGHTS(`MLP_OUT_W0),
		.BIAS(`MLP_OUT_B0),
		.RELU(1'b0)
	) output0_i (
		.clk(clk),
		.reset(reset),
		.neuronIn({hidden2, hidden1, hidden0}),
		.neuronOut(score0)
	);

	neuron #(
		.NIN(`MLP_NUM_HIDDEN),
		.WEIGHTS(`MLP_OUT_W1),
		.BIAS(`MLP_OUT_B1),
		.RELU(1'b0)
	) output1_i (
		.clk(clk),
		.reset(reset),
		.neuronIn({hidden2, hidden1, hidden0}),
		.neuronOut(score1)
	);

	neuron #(
		.NIN(`MLP_NUM_HIDDEN),
		.WEIGHTS(`MLP_OUT_W2),
		.BIAS(`MLP_OUT_B2),
		.RELU(1'b0)
	) output2_i (
		.clk(clk),
		.reset(reset),
		.neuronIn({hidden2, hidden1, hidden0}),
		.neuronOut(score2)
	);

	argmaxSelect argmaxSelect_i (
		.clk(clk),
		.reset(reset),
		.score0(score0),
		.score1(score1),
		.score2(score2),
		.classIndex(classIndex),
		.classScore(classScore)
	);

endmodule

// ==== design/mlpWeights.svh ====
`ifndef MLP_WEIGHTS_SVH
`define MLP_WEIGHTS_SVH

// ********************************************************************
// hidden layer, four Q8.8 weights per neuron
// ********************************************************************

// word i of a packed table sits at bits [16*i +: 16], so the
// rightmost literal below is the weight on input 0.

// w0 = 1.5, w1 = -1.0, w2 = 0.25, w3 = -0.5.
`define MLP_HID_W0 {16'hFF80, 16'h0040, 16'hFF00, 16'h0180}

// w0 = -1.0, w1 = 1.75, w2 = -0.25, w3 = 0.5.
`define MLP_HID_W1 {16'h0080, 16'hFFC0, 16'h01C0, 16'hFF00}

// w0 = 0.25, w1 = -0.5, w2 = 1.25, w3 = 0.75.
`define MLP_HID_W2 {16'h00C0, 16'h0140, 16'hFF80, 16'h0040}

// small offsets keep the three hidden units from being identical at zero.
`define MLP_HID_B0 16'h0010
`define MLP_HID_B1 16'hFFF0
`define MLP_HID_B2 16'h0000

// ********************************************************************
// output layer, three Q8.8 weights per neuron
// ********************************************************************

// each class favours its own hidden unit and penalises the other two.

// w0 = 1.0, w1 = -0.5, w2 = -0.5.
`define MLP_OUT_W0 {16'hFF80, 16'hFF80, 16'h0100}

// w0 = -0.5, w1 = 1.0, w2 = -0.5.
`define MLP_OUT_W1 {16'hFF80, 16'h0100, 16'hFF80}

// w0 = -0.5, w1 = -0.5, w2 = 1.0.
`define MLP_OUT_W2 {16'h0100, 16'hFF80, 16'hFF80}

// classes 0 and 1 share a bias of 0.125, class 2 sits at -0.125.
// with every hidden unit at zero the first two tie and class 0 wins.
`define MLP_OUT_B0 16'h0020
`define MLP_OUT_B1 16'h0020
`define MLP_OUT_B2 16'hFFE0

`endif

// ==== design/neuron.sv ====
`timescale 1ns/1ps
`include "mlpCfg_cfg.svh"

// ********************************************************************
// fixed-weight neuron, three register stages
// ********************************************************************

module neuron
	import mlpPkg::*;
#(
	parameter int NIN = 4,
	parameter logic [NIN*`MLP_DATA_W-1:0] WEIGHTS = '0,
	parameter logic [`MLP_DATA_W-1:0] BIAS = '0,
	parameter bit RELU = 1'b1
)
(
	input logic clk,
	input logic reset,
	input sample_t [NIN-1:0] neuronIn,
	output sample_t neuronOut
);

	sample_t [NIN-1:0] inReg; // stage 1, captured inputs.
	sample_t [NIN-1:0] product; // scaled products of stage 1.
	sample_t sumNext;
	sample_t sumReg; // stage 2, wrapped weighted sum.

	// ****************************************************************
	// multiply
	// ****************************************************************

	for (genvar i = 0; i < NIN; i++)
	begin : gMul
		logic signed [2*`MLP_DATA_W-1:0] fullProd;

		assign fullProd = $signed(inReg[i]) *
			$signed(WEIGHTS[i*`MLP_DATA_W +: `MLP_DATA_W]);

		// taking these bits is the arithmetic shift by the fraction
		// width followed by truncation back to one data word.
		assign product[i] = fullProd[`MLP_FRAC_BITS +: `MLP_DATA_W];
	end

	// ****************************************************************
	// accumulate
	// ****************************************************************

	// the adder chain is one word wide, so overflow wraps around.
	always_comb
	begin
		sumNext = BIAS;
		for (int i = 0; i < NIN; i++)
		begin
			sumNext = sumNext + product[i];
		end
	end

	// ****************************************************************
	// pipeline registers
	// ****************************************************************

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inReg <= '0;
			sumReg <= '0;
			neuronOut <= '0;
		end
		else
		begin
			inReg <= neuronIn;
			sumReg <= sumNext;

			if (RELU && sumReg[`MLP_DATA_W-1])
			begin
				neuronOut <= '0; // negative sums are clipped.
			end
			else
			begin
				neuronOut <= sumReg;
			end
		end
	end

	// a rectified unit never hands a negative value to the next layer.
	reluNonNegative: assert property (
		@(posedge clk) disable iff (reset)
		RELU |-> !neuronOut[`MLP_DATA_W-1]
	)
	else
		$error("neuron: negative output with ReLU enabled");

endmodule

// ==== sim/clockGen.sv ====
`timescale 1ns/1ps

// ********************************************************************
// free-running clock and power-on reset for the testbench
// ********************************************************************

module clockGen #(
	parameter int PERIOD_NS = 100,
	parameter int RESET_CYCLES = 5
)
(
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// reset drops just after its last rising edge, like any register output.
	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

// ==== sim/mlpTopTb.sv ====
`timescale 1ns/1ps
`include "mlpCfg_cfg.svh"
`include "mlpWeights.svh"

module mlpTopTb
	import mlpPkg::*;
();

	localparam int VEC_W = `MLP_NUM_FEATURES * `MLP_DATA_W;
	localparam int PIPE_LAT = 2 * `MLP_NEURON_LAT + 1; // hidden, output, argmax.
	localparam int NUM_DIRECTED = 14;
	localparam int NUM_RANDOM = 24;
	localparam int NUM_ROWS = NUM_DIRECTED + NUM_RANDOM;
	localparam int RESET_TIMEOUT = 20;

	logic clk;
	logic reset;
	sample_t feature0;
	sample_t feature1;
	sample_t feature2;
	sample_t feature3;
	classIndex_t classIndex;
	sample_t classScore;

	// ********************************************************************
	// stimulus table with word i of a row as feature i
	// ********************************************************************

	logic [VEC_W-1:0] featTab [0:NUM_ROWS-1];
	int handIdxTab [0:NUM_ROWS-1]; // -1 where only the model decides.
	int expIdxTab [0:NUM_ROWS-1];
	sample_t expScoreTab [0:NUM_ROWS-1];

	int idxQ [$];
	sample_t scoreQ [$];
	int handQ [$];

	integer seed = 32'h006e_85cd;
	int errors = 0;
	int checks = 0;
	bit released;

	clockGen #(
		.PERIOD_NS(100),
		.RESET_CYCLES(5)
	) clockGen_i (
		.clk(clk),
		.reset(reset)
	);

	mlpTop mlpTop_i (
		.clk(clk),
		.reset(reset),
		.feature0(feature0),
		.feature1(feature1),
		.feature2(feature2),
		.feature3(feature3),
		.classIndex(classIndex),
		.classScore(classScore)
	);

	// ********************************************************************
	// reference model
	// ********************************************************************

	function automatic logic [VEC_W-1:0] weightsOf(input bit outLayer, input int n);
		if (outLayer)
			return (n == 0) ? `MLP_OUT_W0 : (n == 1) ? `MLP_OUT_W1 : `MLP_OUT_W2;
		else
			return (n == 0) ? `MLP_HID_W0 : (n == 1) ? `MLP_HID_W1 : `MLP_HID_W2;
	endfunction

	function automatic sample_t biasOf(input bit outLayer, input int n);
		if (outLayer)
			return (n == 0) ? `MLP_OUT_B0 : (n == 1) ? `MLP_OUT_B1 : `MLP_OUT_B2;
		else
			return (n == 0) ? `MLP_HID_B0 : (n == 1) ? `MLP_HID_B1 : `MLP_HID_B2;
	endfunction

	// each product is scaled back to Q8.8 and cut to one word; the sum wraps.
	function automatic sample_t neuronModel(input logic [VEC_W-1:0] inVec,
		input logic [VEC_W-1:0] wVec, input int nin, input sample_t bias, input bit relu);
		logic signed [2*`MLP_DATA_W-1:0] full;
		logic signed [2*`MLP_DATA_W-1:0] shifted;
		sample_t acc;
		acc = bias;
		for (int i = 0; i < nin; i++)
		begin
			full = $signed(inVec[i*`MLP_DATA_W +: `MLP_DATA_W]) *
				$signed(wVec[i*`MLP_DATA_W +: `MLP_DATA_W]);
			shifted = full >>> `MLP_FRAC_BITS;
			acc = acc + shifted[`MLP_DATA_W-1:0];
		end
		if (relu && acc < 0)
			acc = '0;
		return acc;
	endfunction

	task automatic predict(input logic [VEC_W-1:0] feats, output int bestIdx,
		output sample_t bestScore);
		logic [VEC_W-1:0] hid;
		sample_t score;
		hid = '0;
		for (int n = 0; n < `MLP_NUM_HIDDEN; n++)
		begin
			hid[n*`MLP_DATA_W +: `MLP_DATA_W] = neuronModel(feats, weightsOf(1'b0, n),
				`MLP_NUM_FEATURES, biasOf(1'b0, n), 1'b1);
		end
		bestIdx = 0;
		bestScore = '0;
		for (int n = 0; n < `MLP_NUM_CLASSES; n++)
		begin
			score = neuronModel(hid, weightsOf(1'b1, n), `MLP_NUM_HIDDEN,
				biasOf(1'b1, n), 1'b0);
			if (n == 0 || score > bestScore) // a tie keeps the lower class.
			begin
				bestIdx = n;
				bestScore = score;
			end
		end
	endtask

	// ********************************************************************
	// table setup
	// ********************************************************************

	task automatic setRow(input int r, input sample_t f0, input sample_t f1,
		input sample_t f2, input sample_t f3, input int hand);
		featTab[r] = {f3, f2, f1, f0};
		handIdxTab[r] = hand;
	endtask

	task automatic fillTable();
		sample_t f [0:3];
		int idx;
		sample_t score;
		// a single active feature pushes one class ahead.
		setRow(0, 16'h0200, 16'h0000, 16'h0000, 16'h0000, 0);
		setRow(1, 16'h0000, 16'h0200, 16'h0000, 16'h0000, 1);
		setRow(2, 16'h0000, 16'h0000, 16'h0200, 16'h0000, 2);
		setRow(3, 16'h0000, 16'h0000, 16'h0000, 16'h0200, 2);
		setRow(4, 16'h0000, 16'h0100, 16'h0000, 16'h0100, 1);

		// all hidden sums negative, so the scores are the output biases.
		setRow(5, 16'hFF00, 16'hFF00, 16'hFF00, 16'hFF00, 0);
		setRow(6, 16'hFC00, 16'hFC00, 16'hFC00, 16'hFC00, 0);

		setRow(7, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 0);
		setRow(8, 16'h0100, 16'h0100, 16'h0000, 16'hFFE0, 0); // hidden0 equals hidden1.

		// magnitudes near full scale wrap both the products and the sum.
		setRow(9, 16'h7F00, 16'h8100, 16'h7F00, 16'h8100, -1);
		setRow(10, 16'h8100, 16'h7F00, 16'h8100, 16'h7F00, -1);
		setRow(11, 16'h7F00, 16'h7F00, 16'h7F00, 16'h7F00, -1);
		setRow(12, 16'h7FFF, 16'h8000, 16'h7FFF, 16'h8000, -1);
		setRow(13, 16'h8000, 16'h8000, 16'h8000, 16'h8000, -1);

		for (int r = NUM_DIRECTED; r < NUM_ROWS; r++)
		begin
			for (int i = 0; i < 4; i++)
				f[i] = sample_t'($random(seed) % 1025); // within +-4.0.
			setRow(r, f[0], f[1], f[2], f[3], -1);
		end

		for (int r = 0; r < NUM_ROWS; r++)
		begin
			predict(featTab[r], idx, score);
			expIdxTab[r] = idx;
			expScoreTab[r] = score;
		end
	endtask

	// ********************************************************************
	// checks and drive
	// ********************************************************************

	task automatic compareField(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		checks++;
		assert (actual === expected)
		else
		begin
			errors++;
			$display("[FAIL] %0d ns: %s expected %h, got %h",
				$time, name, expected, actual);
		end
	endtask

	task automatic checkResetState();
		compareField("classIndex", 16'd0, classIndex);
		compareField("classScore", 16'd0, classScore);
	endtask

	task automatic driveFeatures(input logic [VEC_W-1:0] v);
		feature0 = v[0 +: `MLP_DATA_W];
		feature1 = v[`MLP_DATA_W +: `MLP_DATA_W];
		feature2 = v[2*`MLP_DATA_W +: `MLP_DATA_W];
		feature3 = v[3*`MLP_DATA_W +: `MLP_DATA_W];
	endtask

	task automatic waitForReset(output bit ok);
		int waited;
		waited = 0;
		@(posedge clk); // the first edge loads the reset values.
		@(negedge clk);
		while (reset && waited < RESET_TIMEOUT)
		begin
			checkResetState();
			waited++;
			@(negedge clk);
		end
		ok = !reset;
	endtask

	// one row per falling edge; a row's result is checked PIPE_LAT edges later.
	task automatic applyTable();
		int hand;
		for (int c = 0; c < NUM_ROWS + PIPE_LAT; c++)
		begin
			if (c == 0)
				checkResetState();
			else if (c < PIPE_LAT)
				compareField("classIndex", 16'd0, classIndex); // the fill carries only biases.
			else
			begin
				compareField("classIndex", idxQ.pop_front(), classIndex);
				compareField("classScore", scoreQ.pop_front(), classScore);
				hand = handQ.pop_front();
				if (hand >= 0)
					compareField("classIndex", hand, classIndex);
			end

			if (c < NUM_ROWS)
			begin
				driveFeatures(featTab[c]);
				idxQ.push_back(expIdxTab[c]);
				scoreQ.push_back(expScoreTab[c]);
				handQ.push_back(handIdxTab[c]);
			end
			else
				driveFeatures('0);
			@(negedge clk);
		end
	endtask

	initial
	begin
		driveFeatures('0);
		fillTable();
		waitForReset(released);
		if (!released)
		begin
			$display("reset never released within %0d cycles", RESET_TIMEOUT);
			$display("sim failed");
		end
		else
		begin
			applyTable();
			$display("checks: %0d, errors: %0d", checks, errors);
			if (errors == 0)
				$display("sim passed");
			else
				$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+design
design/mlpPkg.sv
design/neuron.sv
design/argmaxSelect.sv
design/mlpTop.sv
sim/clockGen.sv
sim/mlpTopTb.sv
